// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing -Wno-fatal
TOP = decode_tb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "TEST OK"

clean:
	rm -rf obj_dir

// File: filelist.f
hdl/decode_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/decode_top.sv
sim/decode_tb.sv

// File: hdl/decode_pkg.sv
package decode_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_fence = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  localparam logic [31:0] instr_ecall = 32'h00000073;
  localparam logic [31:0] instr_ebreak = 32'h00100073;

  localparam logic [3:0] except_illegal_instruction = 4'd2;
  localparam logic [3:0] except_breakpoint = 4'd3;
  localparam logic [3:0] except_env_call_mach = 4'd11;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [3:0] {
    lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw, lsu_none
  } lsu_op_t;

  typedef enum logic [2:0] {
    bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu, bcu_none
  } bcu_op_t;

  typedef struct packed {
    logic [xlen-1:0] imm;
    logic wren;
    logic rden1;
    logic rden2;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fence;
    logic ecall;
    logic ebreak;
    logic nop;
    logic basic; // Lane 1 may take this instruction.
    logic valid;
    alu_op_t alu_op;
    bcu_op_t bcu_op;
    lsu_op_t lsu_op;
  } decoder_out_t;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fence;
    logic ecall;
    logic ebreak;
    logic nop;
    logic valid;
    logic exception;
    logic basic;
  } operation_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0] instr;
    logic [reg_addr_width-1:0] waddr;
    logic [reg_addr_width-1:0] raddr1;
    logic [reg_addr_width-1:0] raddr2;
    logic [xlen-1:0] imm;
    operation_t op;
    alu_op_t alu_op;
    bcu_op_t bcu_op;
    lsu_op_t lsu_op;
    logic [3:0] ecause;
    logic [xlen-1:0] etval;
  } lane_t;

  typedef struct packed {
    logic [xlen-1:0] pc0;
    logic [31:0] instr0;
    logic [xlen-1:0] pc1;
    logic [31:0] instr1;
    logic valid0;
    logic valid1;
  } fetch_bundle_t;

  typedef struct packed {
    logic load;
    logic [reg_addr_width-1:0] waddr;
    logic stall;
    logic redirect;
  } exec_hazard_t;

  typedef struct packed {
    logic rden1;
    logic rden2;
    logic [reg_addr_width-1:0] raddr1;
    logic [reg_addr_width-1:0] raddr2;
  } reg_read_t;

  typedef struct packed {
    logic wren;
    logic [reg_addr_width-1:0] waddr;
    logic [xlen-1:0] wdata;
  } writeback_t;

  typedef struct packed {
    lane_t lane0;
    lane_t lane1;
    logic [xlen-1:0] rdata1_0;
    logic [xlen-1:0] rdata2_0;
    logic [xlen-1:0] rdata1_1;
    logic [xlen-1:0] rdata2_1;
  } issue_t;

  localparam decoder_out_t init_decoder = '{
    alu_op: alu_add, bcu_op: bcu_none, lsu_op: lsu_none, default: '0
  };

  localparam operation_t init_operation = '0;

  localparam lane_t init_lane = '{
    op: init_operation, alu_op: alu_add, bcu_op: bcu_none, lsu_op: lsu_none, default: '0
  };

endpackage

// File: hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic clock,
  input  logic reset,
  input  decode_pkg::fetch_bundle_t fetch,
  input  decode_pkg::decoder_out_t decoder0_out,
  input  decode_pkg::decoder_out_t decoder1_out,
  input  decode_pkg::exec_hazard_t exec,
  input  logic flush,
  output decode_pkg::reg_read_t read0,
  output decode_pkg::reg_read_t read1,
  output logic hold,
  output decode_pkg::lane_t [1:0] lanes,
  output logic stall
);

  decode_pkg::lane_t lane0;
  decode_pkg::lane_t lane1;
  logic hazard;
  logic clear;

  function automatic decode_pkg::lane_t build_lane(
    input logic [decode_pkg::xlen-1:0] pc,
    input logic [31:0] instr,
    input decode_pkg::decoder_out_t dec
  );
    decode_pkg::lane_t lane;
    lane = decode_pkg::init_lane;
    lane.pc = pc;
    lane.instr = instr;
    lane.waddr = instr[11:7];
    lane.raddr1 = instr[19:15];
    lane.raddr2 = instr[24:20];
    lane.imm = dec.imm;
    lane.op.wren = dec.wren;
    lane.op.rden1 = dec.rden1;
    lane.op.rden2 = dec.rden2;
    lane.op.auipc = dec.auipc;
    lane.op.lui = dec.lui;
    lane.op.jal = dec.jal;
    lane.op.jalr = dec.jalr;
    lane.op.branch = dec.branch;
    lane.op.load = dec.load;
    lane.op.store = dec.store;
    lane.op.fence = dec.fence;
    lane.op.ecall = dec.ecall;
    lane.op.ebreak = dec.ebreak;
    lane.op.nop = dec.nop;
    lane.op.valid = dec.valid;
    lane.op.basic = dec.basic;
    lane.alu_op = dec.alu_op;
    lane.bcu_op = dec.bcu_op;
    lane.lsu_op = dec.lsu_op;
    return lane;
  endfunction

  // True when the load in execute writes a register this lane reads.
  function automatic logic load_hit(
    input decode_pkg::lane_t lane,
    input decode_pkg::exec_hazard_t ex
  );
    return ex.load && ((lane.op.rden1 && lane.raddr1 == ex.waddr) ||
                       (lane.op.rden2 && lane.raddr2 == ex.waddr));
  endfunction

  always_comb begin
    lane0 = build_lane(fetch.pc0, fetch.instr0, decoder0_out);
    lane1 = build_lane(fetch.pc1, fetch.instr1, decoder1_out);

    if (!fetch.valid0) begin
      lane0.op = decode_pkg::init_operation;
    end else if (!lane0.op.valid) begin
      lane0.op.exception = 1'b1;
      lane0.ecause = decode_pkg::except_illegal_instruction;
      lane0.etval = lane0.instr;
    end else if (lane0.op.ebreak) begin
      lane0.op.exception = 1'b1;
      lane0.ecause = decode_pkg::except_breakpoint;
      lane0.etval = lane0.instr;
    end else if (lane0.op.ecall) begin
      lane0.op.exception = 1'b1;
      lane0.ecause = decode_pkg::except_env_call_mach;
      lane0.etval = lane0.instr;
    end

    if (!(fetch.valid1 && lane1.op.basic)) begin
      lane1.op = decode_pkg::init_operation; // Lane 1 only runs basic integer work.
    end

    read0.rden1 = lane0.op.rden1;
    read0.rden2 = lane0.op.rden2;
    read0.raddr1 = lane0.raddr1;
    read0.raddr2 = lane0.raddr2;
    read1.rden1 = lane1.op.rden1;
    read1.rden2 = lane1.op.rden2;
    read1.raddr1 = lane1.raddr1;
    read1.raddr2 = lane1.raddr2;

    clear = flush | exec.redirect;
    hazard = load_hit(lane0, exec) | load_hit(lane1, exec);
    stall = hazard & ~clear & reset; // Dropped work needs no replay.

    if (hazard || clear) begin
      lane0.op = decode_pkg::init_operation;
      lane1.op = decode_pkg::init_operation;
    end
  end

  assign hold = exec.stall;

  // A flush still empties the stage while execute is stalled.
  always_ff @(posedge clock) begin
    if (!reset) begin
      lanes[0] <= decode_pkg::init_lane;
      lanes[1] <= decode_pkg::init_lane;
    end else if (!exec.stall || clear) begin
      lanes[0] <= lane0;
      lanes[1] <= lane1;
    end
  end

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/10ps

module decode_top (
  input  logic clock,
  input  logic reset,
  input  decode_pkg::fetch_bundle_t fetch,
  input  decode_pkg::exec_hazard_t exec,
  input  logic flush,
  input  decode_pkg::writeback_t write,
  output decode_pkg::issue_t issue,
  output logic stall
);

  decode_pkg::decoder_out_t decoder0_out;
  decode_pkg::decoder_out_t decoder1_out;
  decode_pkg::reg_read_t read0;
  decode_pkg::reg_read_t read1;
  decode_pkg::lane_t [1:0] lanes;
  logic [3:0][decode_pkg::xlen-1:0] rdata;
  logic hold;

  instr_decoder decoder0_inst (
    .instr   (fetch.instr0),
    .decoded (decoder0_out)
  );

  instr_decoder decoder1_inst (
    .instr   (fetch.instr1),
    .decoded (decoder1_out)
  );

  decode_stage decode_stage_inst (
    .clock        (clock),
    .reset        (reset),
    .fetch        (fetch),
    .decoder0_out (decoder0_out),
    .decoder1_out (decoder1_out),
    .exec         (exec),
    .flush        (flush),
    .read0        (read0),
    .read1        (read1),
    .hold         (hold),
    .lanes        (lanes),
    .stall        (stall)
  );

  register_file register_file_inst (
    .clock (clock),
    .read0 (read0),
    .read1 (read1),
    .hold  (hold),
    .write (write),
    .rdata (rdata)
  );

  assign issue.lane0 = lanes[0];
  assign issue.lane1 = lanes[1];
  assign issue.rdata1_0 = rdata[0];
  assign issue.rdata2_0 = rdata[1];
  assign issue.rdata1_1 = rdata[2];
  assign issue.rdata2_1 = rdata[3];

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  logic [31:0] instr,
  output decode_pkg::decoder_out_t decoded
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [decode_pkg::xlen-1:0] imm_i;
  logic [decode_pkg::xlen-1:0] imm_s;
  logic [decode_pkg::xlen-1:0] imm_b;
  logic [decode_pkg::xlen-1:0] imm_u;
  logic [decode_pkg::xlen-1:0] imm_j;
  logic legal;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Shared by OP and OP-IMM; alt selects sub or sra.
  function automatic decode_pkg::alu_op_t alu_select(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'b001: return decode_pkg::alu_sll;
      3'b010: return decode_pkg::alu_slt;
      3'b011: return decode_pkg::alu_sltu;
      3'b100: return decode_pkg::alu_xor;
      3'b101: return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'b110: return decode_pkg::alu_or;
      default: return decode_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    decoded = decode_pkg::init_decoder;
    legal = 1'b1;
    case (opcode)
      decode_pkg::opcode_lui: begin
        decoded.imm = imm_u;
        decoded.wren = 1'b1;
        decoded.lui = 1'b1;
        decoded.basic = 1'b1;
      end
      decode_pkg::opcode_auipc: begin
        decoded.imm = imm_u;
        decoded.wren = 1'b1;
        decoded.auipc = 1'b1;
        decoded.basic = 1'b1;
      end
      decode_pkg::opcode_jal: begin
        decoded.imm = imm_j;
        decoded.wren = 1'b1;
        decoded.jal = 1'b1;
      end
      decode_pkg::opcode_jalr: begin
        decoded.imm = imm_i;
        decoded.wren = 1'b1;
        decoded.rden1 = 1'b1;
        decoded.jalr = 1'b1;
        legal = (funct3 == 3'b000);
      end
      decode_pkg::opcode_branch: begin
        decoded.imm = imm_b;
        decoded.rden1 = 1'b1;
        decoded.rden2 = 1'b1;
        decoded.branch = 1'b1;
        case (funct3)
          3'b000: decoded.bcu_op = decode_pkg::bcu_beq;
          3'b001: decoded.bcu_op = decode_pkg::bcu_bne;
          3'b100: decoded.bcu_op = decode_pkg::bcu_blt;
          3'b101: decoded.bcu_op = decode_pkg::bcu_bge;
          3'b110: decoded.bcu_op = decode_pkg::bcu_bltu;
          3'b111: decoded.bcu_op = decode_pkg::bcu_bgeu;
          default: legal = 1'b0;
        endcase
      end
      decode_pkg::opcode_load: begin
        decoded.imm = imm_i;
        decoded.wren = 1'b1;
        decoded.rden1 = 1'b1;
        decoded.load = 1'b1;
        case (funct3)
          3'b000: decoded.lsu_op = decode_pkg::lsu_lb;
          3'b001: decoded.lsu_op = decode_pkg::lsu_lh;
          3'b010: decoded.lsu_op = decode_pkg::lsu_lw;
          3'b100: decoded.lsu_op = decode_pkg::lsu_lbu;
          3'b101: decoded.lsu_op = decode_pkg::lsu_lhu;
          default: legal = 1'b0;
        endcase
      end
      decode_pkg::opcode_store: begin
        decoded.imm = imm_s;
        decoded.rden1 = 1'b1;
        decoded.rden2 = 1'b1;
        decoded.store = 1'b1;
        case (funct3)
          3'b000: decoded.lsu_op = decode_pkg::lsu_sb;
          3'b001: decoded.lsu_op = decode_pkg::lsu_sh;
          3'b010: decoded.lsu_op = decode_pkg::lsu_sw;
          default: legal = 1'b0;
        endcase
      end
      decode_pkg::opcode_op_imm: begin
        decoded.imm = imm_i;
        decoded.wren = 1'b1;
        decoded.rden1 = 1'b1;
        decoded.basic = 1'b1;
        decoded.alu_op = alu_select(funct3, (funct3 == 3'b101) && instr[30]);
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000); // Shift amounts above 31 are reserved.
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      end
      decode_pkg::opcode_op: begin
        decoded.wren = 1'b1;
        decoded.rden1 = 1'b1;
        decoded.rden2 = 1'b1;
        decoded.basic = 1'b1;
        decoded.alu_op = alu_select(funct3, instr[30]);
        legal = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      decode_pkg::opcode_fence: begin
        decoded.fence = 1'b1;
        legal = (funct3 == 3'b000);
      end
      decode_pkg::opcode_system: begin
        if (instr == decode_pkg::instr_ecall) begin
          decoded.ecall = 1'b1;
        end else if (instr == decode_pkg::instr_ebreak) begin
          decoded.ebreak = 1'b1;
        end else begin
          legal = 1'b0; // CSR access is not supported here.
        end
      end
      default: legal = 1'b0;
    endcase
    decoded.nop = decoded.basic && (instr[11:7] == '0); // Result goes to x0.
    if (legal) begin
      decoded.valid = 1'b1;
    end else begin
      decoded = decode_pkg::init_decoder;
    end
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic clock,
  input  decode_pkg::reg_read_t read0,
  input  decode_pkg::reg_read_t read1,
  input  logic hold,
  input  decode_pkg::writeback_t write,
  output logic [3:0][decode_pkg::xlen-1:0] rdata
);

  logic [decode_pkg::xlen-1:0] regs [1:31];

  function automatic logic [decode_pkg::xlen-1:0] read_port(
    input logic rden,
    input logic [decode_pkg::reg_addr_width-1:0] raddr
  );
    if (rden && raddr != '0) begin
      return regs[raddr];
    end
    return '0; // x0 and disabled ports read as zero.
  endfunction

  always_ff @(posedge clock) begin
    if (write.wren && write.waddr != '0) begin
      regs[write.waddr] <= write.wdata;
    end
  end

  // Reads see the array before this edge's write.
  always_ff @(posedge clock) begin
    if (!hold) begin
      rdata[0] <= read_port(read0.rden1, read0.raddr1);
      rdata[1] <= read_port(read0.rden2, read0.raddr2);
      rdata[2] <= read_port(read1.rden1, read1.raddr1);
      rdata[3] <= read_port(read1.rden2, read1.raddr2);
    end
  end

endmodule

// File: sim/decode_tb.sv
`timescale 1ns/10ps

module decode_tb;

  localparam int clock_period = 8;
  localparam int reset_cycles = 10;
  localparam int preload_cycles = 31;
  localparam int test_cycles = 3000;
  localparam int watchdog_ns =
    (reset_cycles + preload_cycles + test_cycles + 4) * clock_period + 500;

  logic clock = 1'b0;
  logic reset;
  decode_pkg::fetch_bundle_t fetch;
  decode_pkg::exec_hazard_t exec;
  logic flush;
  decode_pkg::writeback_t write;
  decode_pkg::issue_t issue;
  logic stall;

  integer seed = 67173;

  decode_pkg::lane_t exp_lane0;
  decode_pkg::lane_t exp_lane1;
  logic [31:0] exp_rdata [0:3];
  logic exp_stall;
  logic [31:0] model_regs [0:31];

  decode_top decode_top_inst (
    .clock (clock),
    .reset (reset),
    .fetch (fetch),
    .exec  (exec),
    .flush (flush),
    .write (write),
    .issue (issue),
    .stall (stall)
  );

  initial begin
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not get through its test cycles in time.");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired.");
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  function automatic decode_pkg::alu_op_t alu_for_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'd1: return decode_pkg::alu_sll;
      3'd2: return decode_pkg::alu_slt;
      3'd3: return decode_pkg::alu_sltu;
      3'd4: return decode_pkg::alu_xor;
      3'd5: return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'd6: return decode_pkg::alu_or;
      default: return decode_pkg::alu_and;
    endcase
  endfunction

  // Expected lane for one word, before the hazard and flush rules.
  function automatic decode_pkg::lane_t model_lane(input logic [31:0] pc, input logic [31:0] w,
                                                   input logic present, input logic second);
    decode_pkg::lane_t l;
    logic legal;
    logic [2:0] f3;
    logic [6:0] f7;
    l = decode_pkg::init_lane;
    f3 = w[14:12];
    f7 = w[31:25];
    legal = 1'b1;
    l.pc = pc;
    l.instr = w;
    l.waddr = w[11:7];
    l.raddr1 = w[19:15];
    l.raddr2 = w[24:20];
    case (w[6:0])
      7'h37: begin
        l.imm = {w[31:12], 12'h000};
        l.op.wren = 1'b1;
        l.op.lui = 1'b1;
        l.op.basic = 1'b1;
      end
      7'h17: begin
        l.imm = {w[31:12], 12'h000};
        l.op.wren = 1'b1;
        l.op.auipc = 1'b1;
        l.op.basic = 1'b1;
      end
      7'h6f: begin
        l.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        l.op.wren = 1'b1;
        l.op.jal = 1'b1;
      end
      7'h67: begin
        l.imm = {{20{w[31]}}, w[31:20]};
        l.op.wren = 1'b1;
        l.op.rden1 = 1'b1;
        l.op.jalr = 1'b1;
        legal = (f3 == 3'd0);
      end
      7'h63: begin
        l.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        l.op.rden1 = 1'b1;
        l.op.rden2 = 1'b1;
        l.op.branch = 1'b1;
        case (f3)
          3'd0: l.bcu_op = decode_pkg::bcu_beq;
          3'd1: l.bcu_op = decode_pkg::bcu_bne;
          3'd4: l.bcu_op = decode_pkg::bcu_blt;
          3'd5: l.bcu_op = decode_pkg::bcu_bge;
          3'd6: l.bcu_op = decode_pkg::bcu_bltu;
          3'd7: l.bcu_op = decode_pkg::bcu_bgeu;
          default: legal = 1'b0;
        endcase
      end
      7'h03: begin
        l.imm = {{20{w[31]}}, w[31:20]};
        l.op.wren = 1'b1;
        l.op.rden1 = 1'b1;
        l.op.load = 1'b1;
        case (f3)
          3'd0: l.lsu_op = decode_pkg::lsu_lb;
          3'd1: l.lsu_op = decode_pkg::lsu_lh;
          3'd2: l.lsu_op = decode_pkg::lsu_lw;
          3'd4: l.lsu_op = decode_pkg::lsu_lbu;
          3'd5: l.lsu_op = decode_pkg::lsu_lhu;
          default: legal = 1'b0;
        endcase
      end
      7'h23: begin
        l.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        l.op.rden1 = 1'b1;
        l.op.rden2 = 1'b1;
        l.op.store = 1'b1;
        case (f3)
          3'd0: l.lsu_op = decode_pkg::lsu_sb;
          3'd1: l.lsu_op = decode_pkg::lsu_sh;
          3'd2: l.lsu_op = decode_pkg::lsu_sw;
          default: legal = 1'b0;
        endcase
      end
      7'h13: begin
        l.imm = {{20{w[31]}}, w[31:20]};
        l.op.wren = 1'b1;
        l.op.rden1 = 1'b1;
        l.op.basic = 1'b1;
        l.alu_op = alu_for_funct3(f3, f3 == 3'd5 && f7 == 7'h20);
        if (f3 == 3'd1) legal = (f7 == 7'h00);
        if (f3 == 3'd5) legal = (f7 == 7'h00 || f7 == 7'h20);
      end
      7'h33: begin
        l.op.wren = 1'b1;
        l.op.rden1 = 1'b1;
        l.op.rden2 = 1'b1;
        l.op.basic = 1'b1;
        l.alu_op = alu_for_funct3(f3, f7 == 7'h20);
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end
      7'h0f: begin
        l.op.fence = 1'b1;
        legal = (f3 == 3'd0);
      end
      7'h73: begin
        if (w == 32'h00000073) l.op.ecall = 1'b1;
        else if (w == 32'h00100073) l.op.ebreak = 1'b1;
        else legal = 1'b0;
      end
      default: legal = 1'b0;
    endcase
    l.op.nop = l.op.basic && (w[11:7] == 5'd0);
    l.op.valid = legal;
    if (!legal) begin
      l.imm = '0;
      l.op = decode_pkg::init_operation;
      l.alu_op = decode_pkg::alu_add;
      l.bcu_op = decode_pkg::bcu_none;
      l.lsu_op = decode_pkg::lsu_none;
    end
    if (!second) begin
      if (!present) begin
        l.op = decode_pkg::init_operation;
      end else if (!legal || l.op.ebreak || l.op.ecall) begin
        l.op.exception = 1'b1;
        l.etval = w;
        if (!legal) l.ecause = decode_pkg::except_illegal_instruction;
        else if (l.op.ebreak) l.ecause = decode_pkg::except_breakpoint;
        else l.ecause = decode_pkg::except_env_call_mach;
      end
    end else if (!(present && l.op.basic)) begin
      l.op = decode_pkg::init_operation; // Lane 1 drops anything that is not basic.
    end
    return l;
  endfunction

  function automatic logic load_use_hit(input decode_pkg::lane_t l);
    return exec.load && ((l.op.rden1 && l.raddr1 == exec.waddr) ||
                         (l.op.rden2 && l.raddr2 == exec.waddr));
  endfunction

  function automatic logic [31:0] read_model(input logic rden, input logic [4:0] addr);
    if (!rden || addr == 5'd0) return 32'd0;
    return model_regs[addr];
  endfunction

  // Works out what the DUT shows after the next rising edge.
  task automatic predict_next();
    decode_pkg::lane_t l0;
    decode_pkg::lane_t l1;
    logic clear;
    logic hit;
    l0 = model_lane(fetch.pc0, fetch.instr0, fetch.valid0, 1'b0);
    l1 = model_lane(fetch.pc1, fetch.instr1, fetch.valid1, 1'b1);
    clear = flush | exec.redirect;
    hit = load_use_hit(l0) | load_use_hit(l1);
    exp_stall = hit & ~clear & reset;
    if (!exec.stall) begin
      exp_rdata[0] = read_model(l0.op.rden1, l0.raddr1);
      exp_rdata[1] = read_model(l0.op.rden2, l0.raddr2);
      exp_rdata[2] = read_model(l1.op.rden1, l1.raddr1);
      exp_rdata[3] = read_model(l1.op.rden2, l1.raddr2);
    end
    if (hit || clear) begin
      l0.op = decode_pkg::init_operation;
      l1.op = decode_pkg::init_operation;
    end
    if (!reset) begin
      exp_lane0 = decode_pkg::init_lane;
      exp_lane1 = decode_pkg::init_lane;
    end else if (!exec.stall || clear) begin
      exp_lane0 = l0;
      exp_lane1 = l1;
    end
    if (write.wren && write.waddr != 5'd0) begin
      model_regs[write.waddr] = write.wdata; // Seen by reads from the next edge on.
    end
  endtask

  task automatic check_lane(input string name, input decode_pkg::lane_t actual,
                            input decode_pkg::lane_t expected);
    check_value({name, ".pc"}, actual.pc, expected.pc);
    check_value({name, ".instr"}, actual.instr, expected.instr);
    check_value({name, ".waddr"}, actual.waddr, expected.waddr);
    check_value({name, ".raddr1"}, actual.raddr1, expected.raddr1);
    check_value({name, ".raddr2"}, actual.raddr2, expected.raddr2);
    check_value({name, ".imm"}, actual.imm, expected.imm);
    check_value({name, ".op"}, actual.op, expected.op);
    check_value({name, ".alu_op"}, actual.alu_op, expected.alu_op);
    check_value({name, ".bcu_op"}, actual.bcu_op, expected.bcu_op);
    check_value({name, ".lsu_op"}, actual.lsu_op, expected.lsu_op);
    check_value({name, ".ecause"}, actual.ecause, expected.ecause);
    check_value({name, ".etval"}, actual.etval, expected.etval);
  endtask

  task automatic next_cycle();
    @(negedge clock);
    check_value("stall", stall, exp_stall); // Still driven by the previous inputs.
    check_lane("issue.lane0", issue.lane0, exp_lane0);
    check_lane("issue.lane1", issue.lane1, exp_lane1);
    check_value("issue.rdata1_0", issue.rdata1_0, exp_rdata[0]);
    check_value("issue.rdata2_0", issue.rdata2_0, exp_rdata[1]);
    check_value("issue.rdata1_1", issue.rdata1_1, exp_rdata[2]);
    check_value("issue.rdata2_1", issue.rdata2_1, exp_rdata[3]);
  endtask

  // One in eight words is fully random, the rest follow an RV32I opcode.
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    logic [31:0] pick;
    w = $random(seed);
    pick = $random(seed);
    if (pick[2:0] == 3'd0) return w;
    case (pick[31:8] % 24'd11)
      24'd0: w[6:0] = 7'h37;
      24'd1: w[6:0] = 7'h17;
      24'd2: w[6:0] = 7'h6f;
      24'd3: begin
        w[6:0] = 7'h67;
        if (pick[3]) w[14:12] = 3'd0;
      end
      24'd4: w[6:0] = 7'h63;
      24'd5: w[6:0] = 7'h03;
      24'd6: w[6:0] = 7'h23;
      24'd7: begin
        w[6:0] = 7'h13;
        if (w[13:12] == 2'b01 && pick[4:3] != 2'd0) w[31:25] = {1'b0, pick[5], 5'd0};
      end
      24'd8: begin
        w[6:0] = 7'h33;
        if (pick[4:3] != 2'd0) w[31:25] = {1'b0, pick[5], 5'd0};
      end
      24'd9: begin
        w[6:0] = 7'h0f;
        if (pick[3]) w[14:12] = 3'd0;
      end
      default: begin
        if (pick[4:3] == 2'd0) w = 32'h00000073;
        else if (pick[4:3] == 2'd1) w = 32'h00100073;
        else w[6:0] = 7'h73;
      end
    endcase
    return w;
  endfunction

  task automatic drive_random();
    logic [31:0] r;
    r = $random(seed);
    if (!exp_stall) begin // A stalled bundle is presented again.
      fetch.pc0 = $random(seed) & 32'hffff_fffc;
      fetch.pc1 = fetch.pc0 + 32'd4;
      fetch.instr0 = random_word();
      fetch.instr1 = random_word();
      fetch.valid0 = r[0] | r[1];
      fetch.valid1 = r[2] | r[3];
    end
    exec.load = r[4];
    case (r[8:7])
      2'd0: exec.waddr = fetch.instr0[19:15];
      2'd1: exec.waddr = fetch.instr0[24:20];
      2'd2: exec.waddr = fetch.instr1[19:15];
      default: exec.waddr = r[13:9];
    endcase
    exec.stall = (r[16:14] == 3'd0);
    exec.redirect = (r[20:17] == 4'd0);
    flush = (r[24:21] == 4'd0);
    write.wren = r[25];
    write.waddr = r[30:26];
    write.wdata = $random(seed);
  endtask

  initial begin
    reset = 1'b0;
    fetch = '0;
    exec = '0;
    flush = 1'b0;
    write = '0;
    fetch.instr0 = 32'h00000033; // An add that reads x0 twice.
    fetch.instr1 = 32'h00000033;
    fetch.valid0 = 1'b1;
    fetch.valid1 = 1'b1;
    exec.load = 1'b1; // A load to x0 in execute hits both lanes during reset.
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    predict_next();
    repeat (reset_cycles - 1) begin
      next_cycle();
      predict_next();
    end
    for (int i = 1; i <= preload_cycles; i++) begin
      next_cycle();
      reset = 1'b1;
      fetch = '0;
      exec = '0;
      write.wren = 1'b1;
      write.waddr = i[4:0];
      write.wdata = $random(seed); // Every register gets a known value first.
      predict_next();
    end
    repeat (test_cycles) begin
      next_cycle();
      drive_random();
      predict_next();
    end
    next_cycle();
    $display("TEST OK");
    $finish;
  end

endmodule
